//--- sim.f
cpu_pkg.sv
fetch_unit.sv
register_file.sv
decode_unit.sv
execute_unit.sv
mem_access_unit.sv
bus_arbiter.sv
cpu_core.sv
tb_memory.sv
tb_cpu_core.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the cpu_core testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_cpu_core -f sim.f
./obj_dir/Vtb_cpu_core > sim.log
cat sim.log

if grep -q "Simulation failed" sim.log; then
  echo "testbench reported errors, see sim.log"
  exit 1
fi
exit 0

//--- tb_cpu_core.sv
// RV64I core testbench
`timescale 1ns/1ps

module tb_cpu_core;

  localparam int RESET_CYCLES = 8;
  localparam int HALT_TIMEOUT = 3000;
  localparam logic [31:0] EBREAK = 32'h0010_0073;

  logic               clk;
  logic               i_rst;
  logic               i_bus_ready;
  logic               i_bus_rsp_valid;
  cpu_pkg::xlen_t     i_bus_rdata;
  logic               o_bus_valid;
  cpu_pkg::bus_req_t  o_bus_req;
  logic               o_halted;
  logic               random_mode;

  cpu_pkg::inst_t     prog [$];
  cpu_pkg::xlen_t     snapshot [256];
  int                 checks;
  int                 errors;
  int                 stall_errors = 0;
  logic               stall_q = 1'b0;
  cpu_pkg::bus_req_t  stall_req;

  cpu_core uut (
    .clk(clk), .i_rst(i_rst), .i_bus_ready(i_bus_ready),
    .i_bus_rsp_valid(i_bus_rsp_valid), .i_bus_rdata(i_bus_rdata),
    .o_bus_valid(o_bus_valid), .o_bus_req(o_bus_req), .o_halted(o_halted)
  );

  tb_memory mem_model (
    .clk(clk), .i_rst(i_rst), .i_random(random_mode), .i_bus_valid(o_bus_valid),
    .i_bus_req(o_bus_req), .o_bus_ready(i_bus_ready), .o_rsp_valid(i_bus_rsp_valid),
    .o_rdata(i_bus_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // instruction encoders
  function automatic cpu_pkg::inst_t i_type(input logic [6:0] opc, input logic [2:0] f3,
                                            input int rd, input int rs1, input int imm);
    return {imm[11:0], rs1[4:0], f3, rd[4:0], opc};
  endfunction

  function automatic cpu_pkg::inst_t r_type(input logic [6:0] f7, input logic [2:0] f3,
                                            input int rd, input int rs1, input int rs2);
    return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], 7'h33};
  endfunction

  function automatic cpu_pkg::inst_t sd(input int rs2, input int rs1, input int imm);
    return {imm[11:5], rs2[4:0], rs1[4:0], 3'd3, imm[4:0], 7'h23};
  endfunction

  function automatic cpu_pkg::inst_t b_type(input logic [2:0] f3, input int rs1,
                                            input int rs2, input int off);
    return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3, off[4:1], off[11], 7'h63};
  endfunction

  function automatic cpu_pkg::inst_t addi(input int rd, input int rs1, input int imm);
    return i_type(7'h13, 3'd0, rd, rs1, imm);
  endfunction

  function automatic cpu_pkg::inst_t ld(input int rd, input int rs1, input int imm);
    return i_type(7'h03, 3'd3, rd, rs1, imm);
  endfunction

  // background word that differs for every index
  function automatic cpu_pkg::xlen_t fill_value(input int idx);
    return 64'hc3a5_0000_0000_0000 ^ (64'(idx) * 64'h0000_0001_0001_0101);
  endfunction

  task automatic emit(input cpu_pkg::inst_t inst);
    prog.push_back(inst);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // run control and checks
  task automatic start_test();
    @(negedge clk);
    i_rst = 1'b1;
    @(negedge clk);
    prog.delete();
    for (int i = 0; i < 256; i++) begin
      mem_model.write_word(i[7:0], fill_value(i));
    end
  endtask

  task automatic load_program();
    cpu_pkg::xlen_t word;
    for (int k = 0; k < prog.size(); k++) begin
      word = mem_model.read_word(k[8:1]);
      if (k[0]) word[63:32] = prog[k];
      else word[31:0] = prog[k];
      mem_model.write_word(k[8:1], word);
    end
  endtask

  task automatic run_program(input string name, input logic random);
    int cycles;
    load_program();
    random_mode = random;
    repeat (RESET_CYCLES - 1) @(negedge clk);
    i_rst  = 1'b0;
    cycles = 0;
    while (!o_halted && cycles < HALT_TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (!o_halted) begin
      errors++;
      $display("Timeout: %s program did not halt within %0d cycles", name, HALT_TIMEOUT);
    end
  endtask

  task automatic check_word(input int idx, input cpu_pkg::xlen_t exp);
    cpu_pkg::xlen_t got;
    got = mem_model.read_word(idx[7:0]);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("Fail at %0t: mem[%0d] is %h, expected %h", $time, idx, got, exp);
    end
  endtask

  task automatic check_level(input string name, input logic got, input logic exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("Fail at %0t: %s is %b, expected %b", $time, name, got, exp);
    end
  endtask

  // a stalled request must hold until accepted
  always @(posedge clk) begin
    if (stall_q && !i_rst) begin
      assert (o_bus_valid) else begin
        stall_errors++;
        $display("Fail at %0t: o_bus_valid is %b, expected 1", $time, o_bus_valid);
      end
      assert (o_bus_req == stall_req) else begin
        stall_errors++;
        $display("Fail at %0t: o_bus_req is %h, expected %h", $time, o_bus_req, stall_req);
      end
    end
    stall_q   <= !i_rst && o_bus_valid && !i_bus_ready;
    stall_req <= o_bus_req;
  end

  ////////////////////////////////////////////////////////////////////////////
  // directed tests
  task automatic arith_ops(input logic random);
    cpu_pkg::xlen_t a;
    cpu_pkg::xlen_t b;
    cpu_pkg::xlen_t exp [8];
    start_test();
    a      = 64'd1234;
    b      = 64'd0 - 64'd300;
    exp[0] = a - 64'd2000;
    exp[1] = a + b;
    exp[2] = b - a;
    exp[3] = a & b;
    exp[4] = a | b;
    exp[5] = a ^ b;
    exp[6] = 64'd0 - exp[1];
    exp[7] = exp[5] - 64'd2048;
    emit(addi(1, 0, 1024));
    emit(addi(2, 0, 1234));
    emit(addi(3, 0, -300));
    emit(addi(4, 2, -2000));
    emit(r_type(7'h00, 3'd0, 5, 2, 3));
    emit(r_type(7'h20, 3'd0, 6, 3, 2));
    emit(r_type(7'h00, 3'd7, 7, 2, 3));
    emit(r_type(7'h00, 3'd6, 8, 2, 3));
    emit(r_type(7'h00, 3'd4, 9, 2, 3));
    emit(r_type(7'h20, 3'd0, 10, 0, 5));
    emit(addi(11, 9, -2048));
    for (int r = 4; r <= 11; r++) begin
      emit(sd(r, 1, (r - 4) * 8));
    end
    emit(EBREAK);
    if (random) begin
      run_program("random arithmetic", random);
    end else begin
      run_program("arithmetic", random);
    end
    for (int i = 0; i < 8; i++) begin
      check_word(128 + i, exp[i]);
    end
    // rerun under back-pressure must leave the same image
    for (int i = 0; i < 256; i++) begin
      if (random) check_word(i, snapshot[i]);
      else snapshot[i] = mem_model.read_word(i[7:0]);
    end
  endtask

  task automatic load_store_sum();
    cpu_pkg::xlen_t p [3];
    start_test();
    p[0] = 64'hffff_ffff_ffff_fff0;
    p[1] = 64'h0000_0000_0000_0025;
    p[2] = 64'h8000_0000_0000_0001;
    for (int i = 0; i < 3; i++) begin
      mem_model.write_word(8'(140 + i), p[i]);
    end
    emit(addi(1, 0, 1120));
    emit(ld(2, 1, 0));
    emit(ld(3, 1, 8));
    emit(ld(4, 1, 16));
    emit(r_type(7'h00, 3'd0, 5, 2, 3));
    emit(r_type(7'h00, 3'd0, 6, 5, 4));
    emit(sd(5, 1, 24));
    emit(sd(6, 1, 32));
    emit(ld(7, 1, 32));
    emit(r_type(7'h00, 3'd0, 8, 7, 7));
    emit(sd(8, 1, 40));
    emit(EBREAK);
    run_program("load/store", 1'b0);
    check_word(143, p[0] + p[1]);
    check_word(144, p[0] + p[1] + p[2]);
    check_word(145, (p[0] + p[1] + p[2]) * 64'd2);
  endtask

  task automatic branch_paths();
    start_test();
    emit(addi(1, 0, 1280));
    emit(addi(2, 0, 5));
    emit(addi(3, 0, 5));
    emit(addi(4, 0, 7));
    emit(addi(10, 0, 17));
    emit(addi(11, 0, 34));
    emit(addi(12, 0, 51));
    emit(addi(13, 0, 68));
    emit(b_type(3'd0, 2, 3, 8));
    emit(sd(10, 1, 0));
    emit(sd(11, 1, 8));
    emit(b_type(3'd0, 2, 4, 8));
    emit(sd(12, 1, 16));
    emit(b_type(3'd1, 2, 4, 8));
    emit(sd(13, 1, 24));
    emit(b_type(3'd1, 2, 3, 8));
    emit(sd(10, 1, 32));
    // three passes of a backward loop
    emit(addi(5, 0, 3));
    emit(addi(5, 5, -1));
    emit(r_type(7'h00, 3'd0, 6, 6, 4));
    emit(b_type(3'd1, 5, 0, -8));
    emit(sd(6, 1, 40));
    emit(EBREAK);
    run_program("branch", 1'b0);
    check_word(160, fill_value(160));
    check_word(161, 64'd34);
    check_word(162, 64'd51);
    check_word(163, fill_value(163));
    check_word(164, 64'd17);
    check_word(165, 64'd3 * 64'd7);
  endtask

  task automatic zero_register();
    start_test();
    mem_model.write_word(8'd192, 64'h1234_5678_9abc_def0);
    emit(addi(1, 0, 1536));
    emit(ld(0, 1, 0));
    emit(sd(0, 1, 8));
    emit(addi(0, 0, 99));
    emit(sd(0, 1, 16));
    emit(r_type(7'h00, 3'd0, 0, 1, 1));
    emit(sd(0, 1, 24));
    // x12 held 51 before this reset
    emit(sd(12, 1, 32));
    emit(EBREAK);
    run_program("x0", 1'b0);
    check_word(192, 64'h1234_5678_9abc_def0);
    for (int i = 193; i <= 196; i++) begin
      check_word(i, 64'd0);
    end
  endtask

  task automatic halt_hold();
    start_test();
    emit(addi(1, 0, 1792));
    emit(addi(2, 0, 77));
    emit(sd(2, 1, 0));
    emit(EBREAK);
    emit(sd(2, 1, 8));
    emit(sd(2, 1, 16));
    run_program("halt", 1'b0);
    repeat (50) begin
      @(negedge clk);
      check_level("o_halted", o_halted, 1'b1);
      check_level("o_bus_valid", o_bus_valid, 1'b0);
    end
    check_word(224, 64'd77);
    check_word(225, fill_value(225));
    check_word(226, fill_value(226));
  endtask

  initial begin
    i_rst       = 1'b1;
    random_mode = 1'b0;
    checks      = 0;
    errors      = 0;
    arith_ops(1'b0);
    load_store_sum();
    branch_paths();
    zero_register();
    arith_ops(1'b1);
    halt_hold();
    $display("checks: %0d, errors: %0d, bus stall errors: %0d",
             checks, errors, stall_errors);
    if (errors == 0 && stall_errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- tb_memory.sv
// testbench memory model
`timescale 1ns/1ps

module tb_memory (
  input  logic               clk,
  input  logic               i_rst,
  input  logic               i_random,
  input  logic               i_bus_valid,
  input  cpu_pkg::bus_req_t  i_bus_req,
  output logic               o_bus_ready,
  output logic               o_rsp_valid,
  output cpu_pkg::xlen_t     o_rdata
);

  cpu_pkg::xlen_t     mem [256];
  cpu_pkg::bus_req_t  req_q;
  logic               rst_q = 1'b1;
  logic               accept_q = 1'b0;
  logic               ready_q = 1'b0;
  logic               rsp_valid_q = 1'b0;
  cpu_pkg::xlen_t     rdata_q = '0;
  logic [15:0]        lfsr_q = 16'd13;
  logic               busy = 1'b0;
  int                 delay = 0;

  assign o_bus_ready = ready_q;
  assign o_rsp_valid = rsp_valid_q;
  assign o_rdata     = rdata_q;

  // fibonacci taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic logic rand_bit();
    lfsr_q = lfsr_step(lfsr_q);
    return lfsr_q[0];
  endfunction

  function automatic void write_word(input logic [7:0] idx, input cpu_pkg::xlen_t data);
    mem[idx] = data;
  endfunction

  function automatic cpu_pkg::xlen_t read_word(input logic [7:0] idx);
    return mem[idx];
  endfunction

  // request transfers on this edge
  always @(posedge clk) begin
    rst_q    <= i_rst;
    accept_q <= !i_rst && i_bus_valid && ready_q;
    if (!i_rst && i_bus_valid && ready_q) begin
      req_q <= i_bus_req;
    end
  end

  always @(negedge clk) begin
    rsp_valid_q = 1'b0;
    if (rst_q) begin
      busy    = 1'b0;
      ready_q = 1'b0;
    end else begin
      if (accept_q) begin
        busy  = 1'b1;
        delay = 0;
        if (i_random) begin
          if (rand_bit()) delay = delay + 1;
          if (rand_bit()) delay = delay + 2;
        end
      end
      if (busy) begin
        if (delay == 0) begin
          if (req_q.wen) begin
            mem[req_q.addr[10:3]] = req_q.wdata;
          end
          rdata_q     = mem[req_q.addr[10:3]];
          rsp_valid_q = 1'b1;
          busy        = 1'b0;
        end else begin
          delay = delay - 1;
        end
      end
      // one request outstanding at a time
      if (busy) begin
        ready_q = 1'b0;
      end else if (i_random) begin
        ready_q = rand_bit();
      end else begin
        ready_q = 1'b1;
      end
    end
  end

endmodule

//--- cpu_core.sv
// RV64I core top
`timescale 1ns/1ps

module cpu_core (
  input  logic               clk,
  input  logic               i_rst,
  input  logic               i_bus_ready,
  input  logic               i_bus_rsp_valid,
  input  cpu_pkg::xlen_t     i_bus_rdata,
  output logic               o_bus_valid,
  output cpu_pkg::bus_req_t  o_bus_req,
  output logic               o_halted
);

  ////////////////////////////////////////////////////////////////////////////
  // stage handshakes
  logic                  fetch_valid, fetch_ready;
  cpu_pkg::fetch_pkt_t   fetch_pkt;
  logic                  dec_valid, dec_ready;
  cpu_pkg::decode_pkt_t  dec_pkt;
  logic                  exec_valid, exec_ready;
  cpu_pkg::exec_pkt_t    exec_pkt;
  cpu_pkg::redirect_t    redirect;
  logic                  redirect_valid;
  logic                  retire;

  // register file ports
  cpu_pkg::reg_idx_t     rs1, rs2, rd;
  cpu_pkg::xlen_t        rs1_data, rs2_data, rd_data;
  logic                  rd_wen;

  ////////////////////////////////////////////////////////////////////////////
  // requesters to arbiter
  logic                  if_bus_valid, if_bus_ready, if_rsp_valid;
  cpu_pkg::bus_req_t     if_bus_req;
  logic                  ls_bus_valid, ls_bus_ready, ls_rsp_valid;
  cpu_pkg::bus_req_t     ls_bus_req;
  cpu_pkg::xlen_t        rsp_data;

  fetch_unit u_fetch (
    .clk(clk), .i_rst(i_rst), .i_retire(retire), .i_halt(o_halted),
    .i_redirect(redirect), .i_redirect_valid(redirect_valid),
    .i_bus_ready(if_bus_ready), .i_rsp_valid(if_rsp_valid), .i_rsp_data(rsp_data),
    .i_fetch_ready(fetch_ready), .o_bus_valid(if_bus_valid), .o_bus_req(if_bus_req),
    .o_fetch_valid(fetch_valid), .o_fetch(fetch_pkt)
  );

  register_file u_regs (
    .clk(clk), .i_rst(i_rst), .i_rs1(rs1), .i_rs2(rs2), .i_rd(rd), .i_rd_wen(rd_wen),
    .i_rd_data(rd_data), .o_rs1_data(rs1_data), .o_rs2_data(rs2_data)
  );

  decode_unit u_decode (
    .clk(clk), .i_rst(i_rst), .i_fetch_valid(fetch_valid), .i_fetch(fetch_pkt),
    .i_rs1_data(rs1_data), .i_rs2_data(rs2_data), .i_dec_ready(dec_ready),
    .o_fetch_ready(fetch_ready), .o_rs1(rs1), .o_rs2(rs2),
    .o_dec_valid(dec_valid), .o_dec(dec_pkt)
  );

  execute_unit u_execute (
    .clk(clk), .i_rst(i_rst), .i_dec_valid(dec_valid), .i_dec(dec_pkt),
    .i_exec_ready(exec_ready), .o_dec_ready(dec_ready), .o_exec_valid(exec_valid),
    .o_exec(exec_pkt), .o_redirect(redirect), .o_redirect_valid(redirect_valid)
  );

  mem_access_unit u_mem (
    .clk(clk), .i_rst(i_rst), .i_exec_valid(exec_valid), .i_exec(exec_pkt),
    .i_bus_ready(ls_bus_ready), .i_rsp_valid(ls_rsp_valid), .i_rsp_data(rsp_data),
    .o_exec_ready(exec_ready), .o_bus_valid(ls_bus_valid), .o_bus_req(ls_bus_req),
    .o_rd(rd), .o_rd_wen(rd_wen), .o_rd_data(rd_data), .o_retire(retire),
    .o_halted(o_halted)
  );

  bus_arbiter u_arbiter (
    .clk(clk), .i_rst(i_rst), .i_fetch_valid(if_bus_valid), .i_fetch_req(if_bus_req),
    .i_data_valid(ls_bus_valid), .i_data_req(ls_bus_req), .i_bus_ready(i_bus_ready),
    .i_bus_rsp_valid(i_bus_rsp_valid), .i_bus_rdata(i_bus_rdata),
    .o_fetch_ready(if_bus_ready), .o_fetch_rsp_valid(if_rsp_valid),
    .o_data_ready(ls_bus_ready), .o_data_rsp_valid(ls_rsp_valid),
    .o_rsp_data(rsp_data), .o_bus_valid(o_bus_valid), .o_bus_req(o_bus_req)
  );

endmodule

//--- bus_arbiter.sv
// shared memory bus arbiter
`timescale 1ns/1ps

module bus_arbiter (
  input  logic               clk,
  input  logic               i_rst,
  input  logic               i_fetch_valid,
  input  cpu_pkg::bus_req_t  i_fetch_req,
  input  logic               i_data_valid,
  input  cpu_pkg::bus_req_t  i_data_req,
  input  logic               i_bus_ready,
  input  logic               i_bus_rsp_valid,
  input  cpu_pkg::xlen_t     i_bus_rdata,
  output logic               o_fetch_ready,
  output logic               o_fetch_rsp_valid,
  output logic               o_data_ready,
  output logic               o_data_rsp_valid,
  output cpu_pkg::xlen_t     o_rsp_data,
  output logic               o_bus_valid,
  output cpu_pkg::bus_req_t  o_bus_req
);

  logic busy_q;
  logic owner_data_q;
  logic grant_data;
  logic grant_fetch;

  // data side wins a tie
  assign grant_data  = !busy_q && i_data_valid;
  assign grant_fetch = !busy_q && i_fetch_valid && !i_data_valid;

  assign o_bus_valid   = grant_data || grant_fetch;
  assign o_bus_req     = grant_data ? i_data_req : i_fetch_req;
  assign o_data_ready  = grant_data && i_bus_ready;
  assign o_fetch_ready = grant_fetch && i_bus_ready;

  // response goes back to whoever owns the bus
  assign o_data_rsp_valid  = i_bus_rsp_valid && busy_q && owner_data_q;
  assign o_fetch_rsp_valid = i_bus_rsp_valid && busy_q && !owner_data_q;
  assign o_rsp_data        = i_bus_rdata;

  always_ff @(posedge clk) begin
    if (i_rst) begin
      busy_q       <= 1'b0;
      owner_data_q <= 1'b0;
    end else if (o_bus_valid && i_bus_ready) begin
      busy_q       <= 1'b1;
      owner_data_q <= grant_data;
    end else if (i_bus_rsp_valid) begin
      busy_q <= 1'b0;
    end
  end

endmodule

//--- mem_access_unit.sv
// data access, writeback and retire
`timescale 1ns/1ps

module mem_access_unit (
  input  logic                clk,
  input  logic                i_rst,
  input  logic                i_exec_valid,
  input  cpu_pkg::exec_pkt_t  i_exec,
  input  logic                i_bus_ready,
  input  logic                i_rsp_valid,
  input  cpu_pkg::xlen_t      i_rsp_data,
  output logic                o_exec_ready,
  output logic                o_bus_valid,
  output cpu_pkg::bus_req_t   o_bus_req,
  output cpu_pkg::reg_idx_t   o_rd,
  output logic                o_rd_wen,
  output cpu_pkg::xlen_t      o_rd_data,
  output logic                o_retire,
  output logic                o_halted
);

  cpu_pkg::lsu_state_e state_q;
  cpu_pkg::exec_pkt_t  pkt_q;
  cpu_pkg::xlen_t      rd_data_q;
  logic                retire_q;
  logic                halted_q;

  assign o_exec_ready    = (state_q == cpu_pkg::L_IDLE) && !retire_q;
  assign o_bus_valid     = state_q == cpu_pkg::L_REQ;
  assign o_bus_req.addr  = {pkt_q.address[63:3], 3'b000};
  assign o_bus_req.wdata = pkt_q.store_data;
  assign o_bus_req.wen   = pkt_q.mem_wen;

  // regfile writes on the retire edge
  assign o_rd      = pkt_q.rd;
  assign o_rd_wen  = retire_q && pkt_q.rd_wen;
  assign o_rd_data = rd_data_q;
  assign o_retire  = retire_q;
  assign o_halted  = halted_q;

  always_ff @(posedge clk) begin
    if (i_rst) begin
      state_q  <= cpu_pkg::L_IDLE;
      retire_q <= 1'b0;
      halted_q <= 1'b0;
    end else begin
      retire_q <= 1'b0;
      if (retire_q && pkt_q.is_halt) begin
        halted_q <= 1'b1;
      end
      case (state_q)
        cpu_pkg::L_IDLE: begin
          if (i_exec_valid && o_exec_ready) begin
            pkt_q     <= i_exec;
            rd_data_q <= i_exec.result;
            if (i_exec.mem_ren || i_exec.mem_wen) begin
              state_q <= cpu_pkg::L_REQ;
            end else begin
              retire_q <= 1'b1;
            end
          end
        end
        cpu_pkg::L_REQ: begin
          if (i_bus_ready) begin
            state_q <= cpu_pkg::L_WAIT_RSP;
          end
        end
        default: begin
          if (i_rsp_valid) begin
            if (pkt_q.mem_ren) begin
              rd_data_q <= i_rsp_data;
            end
            retire_q <= 1'b1;
            state_q  <= cpu_pkg::L_IDLE;
          end
        end
      endcase
    end
  end

endmodule

//--- execute_unit.sv
// alu and branch resolution
`timescale 1ns/1ps

module execute_unit (
  input  logic                  clk,
  input  logic                  i_rst,
  input  logic                  i_dec_valid,
  input  cpu_pkg::decode_pkt_t  i_dec,
  input  logic                  i_exec_ready,
  output logic                  o_dec_ready,
  output logic                  o_exec_valid,
  output cpu_pkg::exec_pkt_t    o_exec,
  output cpu_pkg::redirect_t    o_redirect,
  output logic                  o_redirect_valid
);

  cpu_pkg::xlen_t      sum;
  cpu_pkg::xlen_t      alu_res;
  logic                eq;
  cpu_pkg::exec_pkt_t  exec_q;
  cpu_pkg::redirect_t  redirect_q;
  logic                exec_valid_q;

  assign sum = i_dec.op1 + i_dec.op2;
  assign eq  = i_dec.op1 == i_dec.op2;

  always_comb begin
    case (i_dec.alu_op)
      cpu_pkg::ALU_SUB: alu_res = i_dec.op1 - i_dec.op2;
      cpu_pkg::ALU_AND: alu_res = i_dec.op1 & i_dec.op2;
      cpu_pkg::ALU_OR:  alu_res = i_dec.op1 | i_dec.op2;
      cpu_pkg::ALU_XOR: alu_res = i_dec.op1 ^ i_dec.op2;
      cpu_pkg::ALU_EQ:  alu_res = {63'd0, eq};
      default:          alu_res = sum;
    endcase
  end

  assign o_dec_ready  = !exec_valid_q;
  assign o_exec_valid = exec_valid_q;
  assign o_exec       = exec_q;
  assign o_redirect   = redirect_q;
  // fetch sees the redirect as the packet moves on
  assign o_redirect_valid = exec_valid_q && i_exec_ready;

  always_ff @(posedge clk) begin
    if (i_rst) begin
      exec_valid_q <= 1'b0;
    end else if (i_dec_valid && o_dec_ready) begin
      exec_valid_q          <= 1'b1;
      exec_q.rd             <= i_dec.rd;
      exec_q.rd_wen         <= i_dec.rd_wen;
      exec_q.result         <= alu_res;
      exec_q.mem_ren        <= i_dec.mem_ren;
      exec_q.mem_wen        <= i_dec.mem_wen;
      exec_q.address        <= sum;
      exec_q.store_data     <= i_dec.store_data;
      exec_q.is_halt        <= i_dec.is_halt;
      redirect_q.taken      <= i_dec.is_branch && (alu_res[0] == i_dec.branch_on_equal);
      redirect_q.target     <= i_dec.pc + i_dec.branch_offset;
    end else if (i_exec_ready) begin
      exec_valid_q <= 1'b0;
    end
  end

endmodule

//--- decode_unit.sv
// instruction decode
`timescale 1ns/1ps

module decode_unit (
  input  logic                  clk,
  input  logic                  i_rst,
  input  logic                  i_fetch_valid,
  input  cpu_pkg::fetch_pkt_t   i_fetch,
  input  cpu_pkg::xlen_t        i_rs1_data,
  input  cpu_pkg::xlen_t        i_rs2_data,
  input  logic                  i_dec_ready,
  output logic                  o_fetch_ready,
  output cpu_pkg::reg_idx_t     o_rs1,
  output cpu_pkg::reg_idx_t     o_rs2,
  output logic                  o_dec_valid,
  output cpu_pkg::decode_pkt_t  o_dec
);

  cpu_pkg::inst_t        inst;
  logic [6:0]            opcode;
  logic [2:0]            funct3;
  logic [6:0]            funct7;
  cpu_pkg::xlen_t        imm_i;
  cpu_pkg::xlen_t        imm_s;
  cpu_pkg::xlen_t        imm_b;
  cpu_pkg::decode_pkt_t  dec_d;
  cpu_pkg::decode_pkt_t  dec_q;
  logic                  dec_valid_q;

  assign inst   = i_fetch.inst;
  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];
  assign o_rs1  = inst[19:15];
  assign o_rs2  = inst[24:20];

  // sign extended immediates
  assign imm_i = {{52{inst[31]}}, inst[31:20]};
  assign imm_s = {{52{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{51{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};

  always_comb begin
    dec_d               = '0;
    dec_d.pc            = i_fetch.pc;
    dec_d.alu_op        = cpu_pkg::ALU_ADD;
    dec_d.op1           = i_rs1_data;
    dec_d.op2           = imm_i;
    dec_d.store_data    = i_rs2_data;
    dec_d.branch_offset = imm_b;
    dec_d.rd            = inst[11:7];
    case (opcode)
      cpu_pkg::OPC_OP_IMM, cpu_pkg::OPC_OP: begin
        dec_d.rd_wen = 1'b1;
        if (opcode == cpu_pkg::OPC_OP) begin
          dec_d.op2 = i_rs2_data;
        end
        case (funct3)
          3'b000: begin
            // sub only exists in the register form
            dec_d.alu_op = (opcode == cpu_pkg::OPC_OP && funct7[5]) ? cpu_pkg::ALU_SUB
                                                                    : cpu_pkg::ALU_ADD;
          end
          3'b100:  dec_d.alu_op = cpu_pkg::ALU_XOR;
          3'b110:  dec_d.alu_op = cpu_pkg::ALU_OR;
          3'b111:  dec_d.alu_op = cpu_pkg::ALU_AND;
          default: dec_d.rd_wen = 1'b0;
        endcase
      end
      cpu_pkg::OPC_LOAD: begin
        dec_d.mem_ren = funct3 == 3'b011;
        dec_d.rd_wen  = funct3 == 3'b011;
      end
      cpu_pkg::OPC_STORE: begin
        dec_d.op2     = imm_s;
        dec_d.mem_wen = funct3 == 3'b011;
      end
      cpu_pkg::OPC_BRANCH: begin
        dec_d.alu_op          = cpu_pkg::ALU_EQ;
        dec_d.op2             = i_rs2_data;
        dec_d.is_branch       = funct3 == 3'b000 || funct3 == 3'b001;
        dec_d.branch_on_equal = funct3 == 3'b000;
      end
      cpu_pkg::OPC_SYSTEM: begin
        dec_d.is_halt = inst == cpu_pkg::INST_EBREAK;
      end
      default: ;
    endcase
  end

  assign o_fetch_ready = !dec_valid_q;
  assign o_dec_valid   = dec_valid_q;
  assign o_dec         = dec_q;

  always_ff @(posedge clk) begin
    if (i_rst) begin
      dec_valid_q <= 1'b0;
    end else if (i_fetch_valid && o_fetch_ready) begin
      dec_valid_q <= 1'b1;
      dec_q       <= dec_d;
    end else if (i_dec_ready) begin
      dec_valid_q <= 1'b0;
    end
  end

endmodule

//--- register_file.sv
// integer register file
`timescale 1ns/1ps

module register_file (
  input  logic                clk,
  input  logic                i_rst,
  input  cpu_pkg::reg_idx_t   i_rs1,
  input  cpu_pkg::reg_idx_t   i_rs2,
  input  cpu_pkg::reg_idx_t   i_rd,
  input  logic                i_rd_wen,
  input  cpu_pkg::xlen_t      i_rd_data,
  output cpu_pkg::xlen_t      o_rs1_data,
  output cpu_pkg::xlen_t      o_rs2_data
);

  cpu_pkg::xlen_t regs [32];

  assign o_rs1_data = regs[i_rs1];
  assign o_rs2_data = regs[i_rs2];

  // x0 is never written so it reads zero
  always_ff @(posedge clk) begin
    if (i_rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (i_rd_wen && (i_rd != 5'd0)) begin
      regs[i_rd] <= i_rd_data;
    end
  end

endmodule

//--- fetch_unit.sv
// instruction fetch
`timescale 1ns/1ps

module fetch_unit (
  input  logic                 clk,
  input  logic                 i_rst,
  input  logic                 i_retire,
  input  logic                 i_halt,
  input  cpu_pkg::redirect_t   i_redirect,
  input  logic                 i_redirect_valid,
  input  logic                 i_bus_ready,
  input  logic                 i_rsp_valid,
  input  cpu_pkg::xlen_t       i_rsp_data,
  input  logic                 i_fetch_ready,
  output logic                 o_bus_valid,
  output cpu_pkg::bus_req_t    o_bus_req,
  output logic                 o_fetch_valid,
  output cpu_pkg::fetch_pkt_t  o_fetch
);

  cpu_pkg::fetch_state_e state_q;
  cpu_pkg::addr_t        pc_q;
  cpu_pkg::redirect_t    redirect_q;
  cpu_pkg::inst_t        inst_q;
  logic                  fetch_valid_q;

  // doubleword aligned read at the pc
  assign o_bus_valid       = state_q == cpu_pkg::F_REQ;
  assign o_bus_req.addr    = {pc_q[63:3], 3'b000};
  assign o_bus_req.wdata   = '0;
  assign o_bus_req.wen     = 1'b0;
  assign o_fetch_valid     = fetch_valid_q;
  assign o_fetch.pc        = pc_q;
  assign o_fetch.inst      = inst_q;

  always_ff @(posedge clk) begin
    if (i_rst) begin
      state_q       <= cpu_pkg::F_IDLE;
      pc_q          <= cpu_pkg::RESET_PC;
      redirect_q    <= '0;
      fetch_valid_q <= 1'b0;
    end else begin
      if (i_redirect_valid) begin
        redirect_q <= i_redirect;
      end
      if (fetch_valid_q && i_fetch_ready) begin
        fetch_valid_q <= 1'b0;
      end
      case (state_q)
        cpu_pkg::F_IDLE: begin
          if (!i_halt) begin
            state_q <= cpu_pkg::F_REQ;
          end
        end
        cpu_pkg::F_REQ: begin
          if (i_bus_ready) begin
            state_q <= cpu_pkg::F_WAIT_RSP;
          end
        end
        cpu_pkg::F_WAIT_RSP: begin
          if (i_rsp_valid) begin
            inst_q        <= pc_q[2] ? i_rsp_data[63:32] : i_rsp_data[31:0];
            fetch_valid_q <= 1'b1;
            state_q       <= cpu_pkg::F_WAIT_RETIRE;
          end
        end
        default: begin
          if (i_retire) begin
            pc_q <= redirect_q.taken ? redirect_q.target : pc_q + 64'd4;
            // ebreak parks the fetch for good
            state_q <= (inst_q == cpu_pkg::INST_EBREAK) ? cpu_pkg::F_IDLE
                                                        : cpu_pkg::F_REQ;
          end
        end
      endcase
    end
  end

endmodule

//--- cpu_pkg.sv
// RV64I core shared definitions
package cpu_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // widths
  typedef logic [63:0] xlen_t;
  typedef logic [63:0] addr_t;
  typedef logic [31:0] inst_t;
  typedef logic [4:0]  reg_idx_t;

  localparam addr_t RESET_PC = 64'h0;

  // major opcodes
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

  localparam inst_t INST_EBREAK = 32'h0010_0073;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_EQ
  } alu_op_e;

  typedef enum logic [1:0] {
    F_IDLE,
    F_REQ,
    F_WAIT_RSP,
    F_WAIT_RETIRE
  } fetch_state_e;

  typedef enum logic [1:0] {
    L_IDLE,
    L_REQ,
    L_WAIT_RSP
  } lsu_state_e;

  ////////////////////////////////////////////////////////////////////////////
  // packets
  typedef struct packed {
    addr_t addr;
    xlen_t wdata;
    logic  wen;
  } bus_req_t;

  typedef struct packed {
    addr_t pc;
    inst_t inst;
  } fetch_pkt_t;

  typedef struct packed {
    addr_t    pc;
    alu_op_e  alu_op;
    xlen_t    op1;
    xlen_t    op2;
    xlen_t    store_data;
    xlen_t    branch_offset;
    reg_idx_t rd;
    logic     rd_wen;
    logic     mem_ren;
    logic     mem_wen;
    logic     is_branch;
    logic     branch_on_equal;
    logic     is_halt;
  } decode_pkt_t;

  typedef struct packed {
    reg_idx_t rd;
    logic     rd_wen;
    xlen_t    result;
    logic     mem_ren;
    logic     mem_wen;
    addr_t    address;
    xlen_t    store_data;
    logic     is_halt;
  } exec_pkt_t;

  typedef struct packed {
    logic  taken;
    addr_t target;
  } redirect_t;

endpackage
